// File: compile.f
+incdir+include
source/des_pkg.sv
source/des_round_if.sv
source/des_key_schedule.sv
source/des_round_unit.sv
source/des_encryption.sv
source/des_core.sv
testbench/tb_clock_gen.sv
testbench/des_tb.sv

// File: Bender.yml
package:
  name: des_core

sources:
  - include_dirs:
      - include
    files:
      - source/des_pkg.sv
      - source/des_round_if.sv
      - source/des_key_schedule.sv
      - source/des_round_unit.sv
      - source/des_encryption.sv
      - source/des_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/des_tb.sv

// File: testbench/des_tb.sv
// Testbench for des_core, known vector plus LFSR driven random blocks
// A negedge monitor compares every done against a queue of expected blocks
`timescale 1ns/1ps
`default_nettype none

module des_tb import des_pkg::*; ();

    localparam int          TIMEOUT_CYCLES = 200;
    localparam int          RANDOM_RUNS    = 40;
    localparam logic [31:0] LFSR_POLY      = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED      = 32'd61;
    localparam des_block_t  KAT_KEY        = 64'h1334_5779_9BBC_DFF1;
    localparam des_block_t  KAT_PLAIN      = 64'h0123_4567_89AB_CDEF;
    localparam des_block_t  KAT_CIPHER     = 64'h85E8_1354_0F0A_B405;

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        decrypt;
    des_block_t  key;
    des_block_t  message;
    logic        done;
    des_block_t  result;
    des_block_t  expected_q [$];   // One entry per accepted request
    logic        done_prev;
    logic [31:0] lfsr;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    des_core u_des_core (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .decrypt (decrypt),
        .key     (key),
        .message (message),
        .done    (done),
        .result  (result)
    );

    // Straight-line DES from the standard tables, MSB is bit 1
    function automatic des_block_t des_ref(input des_block_t k, input des_block_t blk,
                                           input logic dec);
        logic [DES_KEY_PC_W-1:0] cd;
        logic [DES_CD_W-1:0]     c;
        logic [DES_CD_W-1:0]     d;
        des_subkey_t             sub [DES_ROUNDS];
        des_subkey_t             x;
        des_block_t              perm;
        des_block_t              res;
        des_half_t               l;
        des_half_t               r;
        des_half_t               s_out;
        des_half_t               f;
        des_half_t               r_new;
        logic [5:0]              grp;
        int                      kn;
        for (int i = 0; i < DES_KEY_PC_W; i++) cd[DES_KEY_PC_W-1-i] = k[64-PC1_TABLE[i]];
        c = cd[DES_KEY_PC_W-1 -: DES_CD_W];
        d = cd[DES_CD_W-1:0];
        for (int rnd = 0; rnd < DES_ROUNDS; rnd++) begin
            for (int s = 0; s < SHIFT_TABLE[rnd]; s++) begin
                c = {c[DES_CD_W-2:0], c[DES_CD_W-1]};
                d = {d[DES_CD_W-2:0], d[DES_CD_W-1]};
            end
            cd = {c, d};
            for (int i = 0; i < DES_SUBKEY_W; i++) sub[rnd][47-i] = cd[56-PC2_TABLE[i]];
        end
        for (int i = 0; i < DES_BLOCK_W; i++) perm[63-i] = blk[64-IP_TABLE[i]];
        l = perm[63:32];
        r = perm[31:0];
        for (int rnd = 0; rnd < DES_ROUNDS; rnd++) begin
            kn = dec ? (DES_ROUNDS - 1 - rnd) : rnd;    // Decrypt walks keys backwards
            for (int i = 0; i < DES_SUBKEY_W; i++) x[47-i] = r[32-E_TABLE[i]];
            x = x ^ sub[kn];
            for (int b = 0; b < DES_SBOXES; b++) begin
                grp = x[47-6*b -: 6];
                s_out[31-4*b -: 4] = SBOX[b][{grp[5], grp[0], grp[4:1]}];
            end
            for (int i = 0; i < DES_HALF_W; i++) f[31-i] = s_out[32-P_TABLE[i]];
            r_new = l ^ f;
            l     = r;
            r     = r_new;
        end
        perm = {r, l};      // Halves swapped before IP-inverse
        for (int i = 0; i < DES_BLOCK_W; i++) res[63-i] = perm[64-IP_INV_TABLE[i]];
        return res;
    endfunction

    // Galois form, shift right and fold the taps in when bit 0 drops out
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? LFSR_POLY : 32'h0);
    endfunction

    task automatic random_block(output des_block_t v);
        v = '0;
        for (int i = 0; i < DES_BLOCK_W; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[DES_BLOCK_W-2:0], lfsr[0]};   // One step per bit
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n >= TIMEOUT_CYCLES) report_failure("Reset was never released");
            n++;
            @(posedge clk);
        end
    endtask

    // One start pulse, queued for checking only when the DUT should accept it
    task automatic drive_request(input des_block_t k, input des_block_t m, input logic dec,
                                 input des_block_t exp, input logic accepted);
        @(posedge clk);
        #1;
        key     = k;
        message = m;
        decrypt = dec;
        start   = 1'b1;
        if (accepted) begin
            expected_q.push_back(exp);
        end
        @(posedge clk);
        #1 start = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (n >= TIMEOUT_CYCLES) begin
                report_failure($sformatf("done never arrived within %0d cycles", n));
            end
            n++;
            @(negedge clk);
        end
    endtask

    task automatic run_request(input des_block_t k, input des_block_t m, input logic dec,
                               input des_block_t exp);
        drive_request(k, m, dec, exp, 1'b1);
        wait_done();
    endtask

    // Mid-cycle sampling of done and result
    always @(negedge clk) begin
        if (rst_n) begin
            if (done === 1'b1) begin
                if (done_prev) report_failure("done stayed high for more than one cycle");
                if (expected_q.size() == 0) report_failure("done pulsed with no request");
                check_value("result", result, expected_q.pop_front());
            end else if (done !== 1'b0) begin
                report_failure("done is unknown after reset");
            end
            done_prev = (done === 1'b1);
        end
    end

    initial begin
        des_block_t rk;
        des_block_t rm;
        des_block_t rc;
        des_block_t bk;
        des_block_t bm;
        start      = 1'b0;
        decrypt    = 1'b0;
        key        = '0;
        message    = '0;
        lfsr       = LFSR_SEED;
        done_prev  = 1'b0;
        wait_reset();

        // Idle after reset, no done without start
        repeat (10) begin
            @(negedge clk);
            check_value("done", done, 1'b0);
        end

        // Known answer, reference first then DUT both ways
        check_value("des_ref", des_ref(KAT_KEY, KAT_PLAIN, 1'b0), KAT_CIPHER);
        run_request(KAT_KEY, KAT_PLAIN, 1'b0, KAT_CIPHER);
        run_request(KAT_KEY, KAT_CIPHER, 1'b1, KAT_PLAIN);

        // Random pairs, each start lands in the cycle after the previous done
        for (int i = 0; i < RANDOM_RUNS; i++) begin
            random_block(rk);
            random_block(rm);
            rc = des_ref(rk, rm, 1'b0);
            run_request(rk, rm, 1'b0, rc);
            run_request(rk, rc, 1'b1, rm);      // Round trip back to plaintext
        end

        // Second start while busy must be dropped
        random_block(rk);
        random_block(rm);
        random_block(bk);
        random_block(bm);
        drive_request(rk, rm, 1'b0, des_ref(rk, rm, 1'b0), 1'b1);
        repeat (5) @(posedge clk);
        drive_request(bk, bm, 1'b1, '0, 1'b0);
        wait_done();
        repeat (60) @(posedge clk);             // Monitor flags any stray done

        // Back-to-back burst after the busy case
        for (int i = 0; i < 4; i++) begin
            random_block(rk);
            random_block(rm);
            run_request(rk, rm, i[0], des_ref(rk, rm, i[0]));
        end

        repeat (10) @(posedge clk);
        check_value("pending", expected_q.size(), 0);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Testbench clock and reset source, 4 ns period
// Reset is held low for the first 16 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int CLK_HALF_NS  = 2;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever #CLK_HALF_NS clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;    // Released off the edge like other stimulus
    end

endmodule

`default_nettype wire

// File: source/des_core.sv
// DES engine top level
// Pulse start with key, message and decrypt, result is valid while done is high
`timescale 1ns/1ps
`default_nettype none

module des_core import des_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       decrypt,    // High selects reversed key order
    input  des_block_t key,
    input  des_block_t message,
    output logic       done,
    output des_block_t result
);

    des_keyset_t round_keys;   // Combinational, sampled by the controller on start

    des_round_if rif ();

    des_key_schedule u_key_schedule (
        .key        (key),
        .decrypt    (decrypt),
        .round_keys (round_keys)
    );

    des_encryption u_encryption (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .message    (message),
        .round_keys (round_keys),
        .done       (done),
        .result     (result),
        .rif        (rif.ctrl)
    );

    des_round_unit u_round_unit (
        .clk   (clk),
        .rst_n (rst_n),
        .rif   (rif.unit)
    );

endmodule

`default_nettype wire

// File: source/des_encryption.sv
// Iterative DES controller
// Latches IP(message) and the round keys on start, steps the round unit
// sixteen times, then presents IP-inverse of the swapped halves with done
`timescale 1ns/1ps
`default_nettype none

module des_encryption import des_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  des_block_t  message,
    input  des_keyset_t round_keys,
    output logic        done,
    output des_block_t  result,
    des_round_if.ctrl   rif
);

    typedef enum logic [1:0] {
        IDLE,
        ROUNDS,
        FINISHED
    } state_t;

    state_t         state;
    state_t         state_nxt;
    des_round_idx_t round_q;        // Rounds completed so far
    des_block_t     blk_q;          // {L, R} working block
    des_keyset_t    keys_q;         // Current key always in top slot
    logic           accept;
    logic           round_done;
    logic           last_round;

    assign accept     = (state == IDLE) && start;     // Busy starts are dropped
    assign round_done = (state == ROUNDS) && rif.done;
    assign last_round = round_done && (round_q == des_round_idx_t'(DES_ROUNDS - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:     if (start) state_nxt = ROUNDS;
            ROUNDS:   if (last_round) state_nxt = FINISHED;
            FINISHED: state_nxt = IDLE;   // Single done cycle
            default:  state_nxt = IDLE;
        endcase
    end

    // Round counter, wraps to zero on the sixteenth round
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            round_q <= '0;
        end else if (accept) begin
            round_q <= '0;
        end else if (round_done) begin
            round_q <= round_q + 1'b1;
        end
    end

    // Block and key registers
    always_ff @(posedge clk) begin
        if (accept) begin
            blk_q  <= des_ip(message);
            keys_q <= round_keys;
        end else if (round_done) begin
            blk_q  <= {rif.l_out, rif.r_out};
            keys_q <= keys_q << DES_SUBKEY_W;   // Next round key to the top
        end
    end

    // Round unit request
    assign rif.start = (state == ROUNDS);
    assign rif.l_in  = blk_q[DES_BLOCK_W-1 -: DES_HALF_W];
    assign rif.r_in  = blk_q[DES_HALF_W-1:0];
    assign rif.kn    = keys_q[DES_KEYSET_W-1 -: DES_SUBKEY_W];

    // Preoutput is R16 L16, held until the next accepted start
    assign done   = (state == FINISHED);
    assign result = des_ip_inv({blk_q[DES_HALF_W-1:0], blk_q[DES_BLOCK_W-1 -: DES_HALF_W]});

endmodule

`default_nettype wire

// File: source/des_round_unit.sv
// One DES Feistel round per request, result registered
// Answers a held start with a done pulse every other cycle
`timescale 1ns/1ps
`default_nettype none

module des_round_unit import des_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    des_round_if.unit rif
);

    des_subkey_t mixed;     // E(R) xor Kn
    des_half_t   sbox_out;
    des_half_t   f_out;     // Round function result
    logic        take;      // Request accepted this edge
    logic        done_q;

    // Round function f(R, K)
    assign mixed    = des_expand(rif.r_in) ^ rif.kn;
    assign sbox_out = des_sbox_sub(mixed);
    assign f_out    = des_pbox(sbox_out);

    // Skip the edge right after a result, controller reloads halves then
    assign take = rif.start && !done_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= take;     // High for exactly one cycle per take
        end
    end

    // Feistel swap, L' = R and R' = L xor f
    always_ff @(posedge clk) begin
        if (take) begin
            rif.l_out <= rif.r_in;
            rif.r_out <= rif.l_in ^ f_out;
        end
    end

    assign rif.done = done_q;

endmodule

`default_nettype wire

// File: source/des_key_schedule.sv
// Combinational DES key schedule
// Produces all sixteen round keys at once, reversed in order for decryption
`timescale 1ns/1ps
`default_nettype none

module des_key_schedule import des_pkg::*; (
    input  des_block_t  key,
    input  logic        decrypt,
    output des_keyset_t round_keys
);

    logic [DES_KEY_PC_W-1:0] cd_pc1;            // Key after PC1
    logic [DES_CD_W-1:0]     c_rot;             // Running C half
    logic [DES_CD_W-1:0]     d_rot;             // Running D half
    logic [DES_KEY_PC_W-1:0] cd_rot;            // {C, D} fed to PC2
    des_subkey_t             sub [DES_ROUNDS];  // Keys in round order

    // PC1, parity bits fall out here
    always_comb begin
        for (int i = 0; i < DES_KEY_PC_W; i++) begin
            cd_pc1[DES_KEY_PC_W-1-i] = key[DES_BLOCK_W-PC1_TABLE[i]];
        end
    end

    // Rotations accumulate from round to round, PC2 taps each state
    always_comb begin
        c_rot  = cd_pc1[DES_KEY_PC_W-1 -: DES_CD_W];
        d_rot  = cd_pc1[DES_CD_W-1:0];
        cd_rot = cd_pc1;
        for (int r = 0; r < DES_ROUNDS; r++) begin
            for (int s = 0; s < 2; s++) begin
                if (s < SHIFT_TABLE[r]) begin   // One or two steps
                    c_rot = {c_rot[DES_CD_W-2:0], c_rot[DES_CD_W-1]};
                    d_rot = {d_rot[DES_CD_W-2:0], d_rot[DES_CD_W-1]};
                end
            end
            cd_rot = {c_rot, d_rot};
            for (int i = 0; i < DES_SUBKEY_W; i++) begin
                sub[r][DES_SUBKEY_W-1-i] = cd_rot[DES_KEY_PC_W-PC2_TABLE[i]];
            end
        end
    end

    // Packing into the 768-bit bus
    // Encrypt puts round 1 on top, decrypt puts round 16 on top
    always_comb begin
        for (int r = 0; r < DES_ROUNDS; r++) begin
            if (decrypt) begin
                round_keys[(r+1)*DES_SUBKEY_W-1 -: DES_SUBKEY_W] = sub[r];
            end else begin
                round_keys[(DES_ROUNDS-r)*DES_SUBKEY_W-1 -: DES_SUBKEY_W] = sub[r];
            end
        end
    end

endmodule

`default_nettype wire

// File: source/des_round_if.sv
// Request and response bundle between the DES controller and the round unit
// Controller holds start high for a whole run, unit answers with done pulses
`timescale 1ns/1ps
`default_nettype none

interface des_round_if import des_pkg::*; ();

    logic        start;    // Level, high while rounds remain
    des_half_t   l_in;
    des_half_t   r_in;
    des_subkey_t kn;       // Key of the current round
    logic        done;     // One cycle, l_out/r_out valid
    des_half_t   l_out;
    des_half_t   r_out;

    modport ctrl (output start, l_in, r_in, kn, input done, l_out, r_out);
    modport unit (input start, l_in, r_in, kn, output done, l_out, r_out);

endinterface

`default_nettype wire

// File: source/des_pkg.sv
// Shared DES widths, types, tables and permutation helpers
// Imported by the RTL and by the testbench reference model
`default_nettype none

package des_pkg;

    localparam int DES_ROUNDS   = 16;
    localparam int DES_BLOCK_W  = 64;
    localparam int DES_HALF_W   = 32;
    localparam int DES_SUBKEY_W = 48;
    localparam int DES_KEY_PC_W = 56;      // Key width after PC1
    localparam int DES_CD_W     = 28;      // C and D register width
    localparam int DES_SBOXES   = 8;
    localparam int DES_KEYSET_W = DES_ROUNDS * DES_SUBKEY_W;

    typedef logic [DES_BLOCK_W-1:0]  des_block_t;
    typedef logic [DES_HALF_W-1:0]   des_half_t;
    typedef logic [DES_SUBKEY_W-1:0] des_subkey_t;
    typedef logic [DES_KEYSET_W-1:0] des_keyset_t;   // Round 1 key in top slot
    typedef logic [3:0]              des_round_idx_t;

`include "des_tables.svh"

    // Tables count bits 1..N from the MSB, hence the N - entry index
    function automatic des_block_t des_ip(input des_block_t blk);
        des_block_t res;
        for (int i = 0; i < DES_BLOCK_W; i++) begin
            res[DES_BLOCK_W-1-i] = blk[DES_BLOCK_W-IP_TABLE[i]];
        end
        return res;
    endfunction

    function automatic des_block_t des_ip_inv(input des_block_t blk);
        des_block_t res;
        for (int i = 0; i < DES_BLOCK_W; i++) begin
            res[DES_BLOCK_W-1-i] = blk[DES_BLOCK_W-IP_INV_TABLE[i]];
        end
        return res;
    endfunction

    // Right half to 48 bits, edge bits of each group repeated
    function automatic des_subkey_t des_expand(input des_half_t half);
        des_subkey_t res;
        for (int i = 0; i < DES_SUBKEY_W; i++) begin
            res[DES_SUBKEY_W-1-i] = half[DES_HALF_W-E_TABLE[i]];
        end
        return res;
    endfunction

    // Eight 6-to-4 lookups, outer bits pick the row, inner four the column
    function automatic des_half_t des_sbox_sub(input des_subkey_t x);
        des_half_t  res;
        logic [5:0] grp;
        for (int b = 0; b < DES_SBOXES; b++) begin
            grp = x[DES_SUBKEY_W-1-6*b -: 6];
            res[DES_HALF_W-1-4*b -: 4] = SBOX[b][{grp[5], grp[0], grp[4:1]}];
        end
        return res;
    endfunction

    function automatic des_half_t des_pbox(input des_half_t half);
        des_half_t res;
        for (int i = 0; i < DES_HALF_W; i++) begin
            res[DES_HALF_W-1-i] = half[DES_HALF_W-P_TABLE[i]];
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// File: include/des_tables.svh
// DES constant tables, included inside des_pkg after the width localparams
// Entries are 1-based bit numbers counted from the MSB, as in the standard
`ifndef DES_TABLES_SVH
`define DES_TABLES_SVH

// Eight boxes, entry index is {row, col} of the 6-bit group
localparam logic [3:0] SBOX [DES_SBOXES][64] = '{
    '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7,
       0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8,
       4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0,
      15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13},
    '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10,
       3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5,
       0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15,
      13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9},
    '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8,
      13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1,
      13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7,
       1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12},
    '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15,
      13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9,
      10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4,
       3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14},
    '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9,
      14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6,
       4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14,
      11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3},
    '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11,
      10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8,
       9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6,
       4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13},
    '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1,
      13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6,
       1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2,
       6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12},
    '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7,
       1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2,
       7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8,
       2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
};

localparam int E_TABLE [DES_SUBKEY_W] = '{   // 32 -> 48 expansion
    32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
     8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
};

localparam int P_TABLE [DES_HALF_W] = '{
    16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
     2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
};

localparam int PC1_TABLE [DES_KEY_PC_W] = '{   // Drops the parity bits
    57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
    10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
    14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
};

localparam int PC2_TABLE [DES_SUBKEY_W] = '{   // 56 -> 48 selection
    14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
    23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
};

localparam int IP_TABLE [DES_BLOCK_W] = '{
    58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
    62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
    57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
    61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
};

localparam int IP_INV_TABLE [DES_BLOCK_W] = '{
    40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
    38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
    36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
    34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
};

// Left rotations of C and D per round
localparam int SHIFT_TABLE [DES_ROUNDS] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

`endif
